// File: hw/bignum_defines.svh
`ifndef BIGNUM_DEFINES_SVH
`define BIGNUM_DEFINES_SVH

// Width of one operand block in bits
`define BLOCK_WIDTH 32

// Blocks per operand
// Four blocks of 32 bits give a 128-bit operand
`define NUM_BLOCKS 4

`endif

// File: hw/bignum_pkg.sv
`include "bignum_defines.svh"

package bignum_pkg;

    // One operand or result block
    typedef logic [`BLOCK_WIDTH-1:0] block_t;

    // Outcome of the magnitude comparison of A against B
    typedef enum logic [1:0] {
        CMP_NONE    = 2'd0,
        CMP_LESS    = 2'd1,
        CMP_GREATER = 2'd2,
        CMP_EQUAL   = 2'd3
    } cmp_result_t;

endpackage

// File: hw/running_comparator.sv
`timescale 1ns/1ps
`default_nettype none

`include "bignum_defines.svh"

module running_comparator
    import bignum_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst_n,
    input  logic        valid,
    input  block_t      block_a,
    input  block_t      block_b,
    output cmp_result_t result,
    output logic        end_comparison
);

    localparam int N = `NUM_BLOCKS;
    localparam int CNT_W = (N > 1) ? $clog2(N) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(N - 1);

    // Outcome of the blocks seen so far, CMP_NONE when idle
    cmp_result_t      state;
    logic [CNT_W-1:0] block_count;
    logic             last_block;
    logic             a_gt;
    logic             a_lt;

    assign a_gt = block_a > block_b;
    assign a_lt = block_a < block_b;

    assign last_block     = block_count == LAST_CNT;
    assign end_comparison = valid && last_block;

    // A more significant block that differs overrides the stored outcome
    always_comb begin
        case (state)
            CMP_NONE: begin
                if (!valid)
                    result = CMP_NONE;
                else if (a_gt)
                    result = CMP_GREATER;
                else if (a_lt)
                    result = CMP_LESS;
                else
                    result = CMP_EQUAL;
            end
            default: begin
                if (a_gt)
                    result = CMP_GREATER;
                else if (a_lt)
                    result = CMP_LESS;
                else
                    result = state;
            end
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state       <= CMP_NONE;
            block_count <= '0;
        end else if (valid) begin
            if (last_block) begin
                // Operand complete, back to idle for the next one
                state       <= CMP_NONE;
                block_count <= '0;
            end else begin
                state       <= result;
                block_count <= block_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/block_subtractor.sv
`timescale 1ns/1ps
`default_nettype none

module block_subtractor
    import bignum_pkg::*;
(
    input  logic   clk_in,
    input  logic   rst_n,
    input  logic   step,
    input  logic   start,
    input  logic   sub_en,
    input  block_t a,
    input  block_t b,
    output block_t diff
);

    localparam int W = $bits(block_t);

    logic         borrow_q;
    logic         borrow_in;
    logic [W:0]   wide_diff;

    // First block of an operand has no incoming borrow
    assign borrow_in = start ? 1'b0 : borrow_q;

    // Extra top bit comes out set when the block subtraction wraps
    assign wide_diff = {1'b0, a} - {1'b0, b} - {{W{1'b0}}, borrow_in};

    // Pass A through unchanged when no reduction is due
    assign diff = sub_en ? wide_diff[W-1:0] : a;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            borrow_q <= 1'b0;
        end else if (step) begin
            borrow_q <= wide_diff[W];
        end
    end

endmodule

`default_nettype wire

// File: hw/reduce_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bignum_defines.svh"

module reduce_sequencer
    import bignum_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst_n,
    input  logic        load_valid,
    input  block_t      load_a,
    input  block_t      load_b,
    input  cmp_result_t running_result,
    input  logic        cmp_end,
    output logic        cmp_valid,
    output logic        busy,
    output logic        out_valid,
    output logic        out_last,
    output cmp_result_t cmp_result,
    output block_t      sub_a,
    output block_t      sub_b,
    output logic        sub_start,
    output logic        sub_en
);

    localparam int N = `NUM_BLOCKS;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N - 1);

    // Operand buffers indexed by block position
    block_t           a_mem [N];
    block_t           b_mem [N];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             replay;
    logic             take;

    // Loads are accepted only while no replay is running
    assign take      = load_valid && !replay;
    assign cmp_valid = take;

    // Replay occupies exactly the output window, so busy and out_valid coincide
    assign busy      = replay;
    assign out_valid = replay;
    assign out_last  = replay && (rd_idx == LAST_IDX);

    assign sub_a     = a_mem[rd_idx];
    assign sub_b     = b_mem[rd_idx];
    assign sub_start = replay && (rd_idx == '0);

    // Reduce when A is greater than or equal to B
    assign sub_en = (cmp_result == CMP_GREATER) || (cmp_result == CMP_EQUAL);

    always_ff @(posedge clk_in) begin
        if (take) begin
            a_mem[wr_idx] <= load_a;
            b_mem[wr_idx] <= load_b;
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            replay     <= 1'b0;
            wr_idx     <= '0;
            rd_idx     <= '0;
            cmp_result <= CMP_NONE;
        end else if (replay) begin
            if (out_last) begin
                // Busy drops the cycle after the final block
                replay <= 1'b0;
                rd_idx <= '0;
            end else begin
                rd_idx <= rd_idx + 1'b1;
            end
        end else if (take) begin
            if (cmp_end) begin
                // Last block taken, hold the outcome and start replay
                cmp_result <= running_result;
                replay     <= 1'b1;
                wr_idx     <= '0;
            end else begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/cond_reduce_top.sv
`timescale 1ns/1ps
`default_nettype none

module cond_reduce_top
    import bignum_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst_n,
    input  logic        load_valid,
    input  block_t      load_a,
    input  block_t      load_b,
    output logic        busy,
    output logic        out_valid,
    output block_t      out_block,
    output logic        out_last,
    output cmp_result_t cmp_result
);

    logic        cmp_valid;
    logic        cmp_end;
    cmp_result_t running_result;
    block_t      sub_a;
    block_t      sub_b;
    logic        sub_start;
    logic        sub_en;

    reduce_sequencer u_sequencer (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .load_valid     (load_valid),
        .load_a         (load_a),
        .load_b         (load_b),
        .running_result (running_result),
        .cmp_end        (cmp_end),
        .cmp_valid      (cmp_valid),
        .busy           (busy),
        .out_valid      (out_valid),
        .out_last       (out_last),
        .cmp_result     (cmp_result),
        .sub_a          (sub_a),
        .sub_b          (sub_b),
        .sub_start      (sub_start),
        .sub_en         (sub_en)
    );

    // Compares the blocks as they are loaded
    running_comparator u_comparator (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .valid          (cmp_valid),
        .block_a        (load_a),
        .block_b        (load_b),
        .result         (running_result),
        .end_comparison (cmp_end)
    );

    // Borrow advances once per output block
    block_subtractor u_subtractor (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .step   (out_valid),
        .start  (sub_start),
        .sub_en (sub_en),
        .a      (sub_a),
        .b      (sub_b),
        .diff   (out_block)
    );

endmodule

`default_nettype wire

// File: tb/cond_reduce_checker.sv
`timescale 1ns/1ps

`include "bignum_defines.svh"

module cond_reduce_checker (
    input logic clk_in,
    input logic rst_n,
    input logic load_valid,
    input logic busy,
    input logic out_valid,
    input logic out_last
);

    localparam int N = `NUM_BLOCKS;

    // Output blocks only start inside a busy window, right after the last load
    property valid_rises_while_busy;
        @(posedge clk_in) disable iff (!rst_n)
            $rose(out_valid) |-> busy && $past(load_valid);
    endproperty

    // The final block is a valid one closing a full run of valid blocks
    property last_with_valid;
        @(posedge clk_in) disable iff (!rst_n)
            out_last |-> out_valid && $past(out_valid, N - 1);
    endproperty

    // Unit is free for the next load right after the final block
    property busy_drops_after_last;
        @(posedge clk_in) disable iff (!rst_n)
            out_last |=> !busy;
    endproperty

    assert property (valid_rises_while_busy)
        else $error("out_valid rose while busy was low or without a load just before");

    assert property (last_with_valid)
        else $error("out_last high without a full run of out_valid");

    assert property (busy_drops_after_last)
        else $error("busy still high one cycle after out_last");

endmodule

bind cond_reduce_top cond_reduce_checker u_checker (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .load_valid (load_valid),
    .busy       (busy),
    .out_valid  (out_valid),
    .out_last   (out_last)
);

// File: tb/cond_reduce_tb.sv
`timescale 1ns/1ps

`include "bignum_defines.svh"

module cond_reduce_tb
    import bignum_pkg::*;
();

    localparam int N = `NUM_BLOCKS;
    localparam int W = `BLOCK_WIDTH;
    localparam int NUM_OPS = 200;
    localparam int TIMEOUT_CYCLES = NUM_OPS * (2 * N + 4) * 2;

    logic        clk_in;
    logic        rst_n;
    logic        load_valid;
    block_t      load_a;
    block_t      load_b;
    logic        busy;
    logic        out_valid;
    block_t      out_block;
    logic        out_last;
    cmp_result_t cmp_result;

    logic [31:0] lcg_state;
    block_t      op_a [N];
    block_t      op_b [N];
    block_t      exp_out [N];
    cmp_result_t exp_cmp;
    int          cycle_count = 0;
    int          valid_count = 0;
    int          last_count = 0;

    cond_reduce_top UUT (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_a     (load_a),
        .load_b     (load_b),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_block  (out_block),
        .out_last   (out_last),
        .cmp_result (cmp_result)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_block(input string name, input block_t expected, input block_t actual);
        if (actual !== expected)
            fail_run($sformatf("** Error at %0t ns: %s expected %h, got %h",
                               $time, name, expected, actual));
    endtask

    task automatic check_result(input string name, input cmp_result_t expected,
                                input cmp_result_t actual);
        if (actual !== expected)
            fail_run($sformatf("** Error at %0t ns: %s expected %s, got %s",
                               $time, name, expected.name(), actual.name()));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            fail_run($sformatf("** Error at %0t ns: %s expected %b, got %b",
                               $time, name, expected, actual));
    endtask

    // Cycle limit and framing counters
    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: run still going after %0d cycles", cycle_count));
        end else begin
            if (rst_n && out_valid)
                valid_count <= valid_count + 1;
            if (rst_n && out_last)
                last_count <= last_count + 1;
        end
    end

    // Mode 0 random, 1 equal, 2 only the low block differs, 3 low and top blocks disagree
    task automatic make_operands(input int mode);
        int     i;
        block_t tmp;
        for (i = 0; i < N; i++) begin
            op_a[i] = block_t'(next_random());
            op_b[i] = block_t'(next_random());
        end
        case (mode)
            1: begin
                for (i = 0; i < N; i++)
                    op_b[i] = op_a[i];
            end
            2: begin
                for (i = 1; i < N; i++)
                    op_b[i] = op_a[i];
            end
            3: begin
                for (i = 1; i < N - 1; i++)
                    op_b[i] = op_a[i];
                if (op_b[N-1] == op_a[N-1])
                    op_b[N-1] = ~op_a[N-1];
                if (op_b[0] == op_a[0])
                    op_b[0] = ~op_a[0];
                if ((op_a[0] > op_b[0]) == (op_a[N-1] > op_b[N-1])) begin
                    tmp     = op_a[0];
                    op_a[0] = op_b[0];
                    op_b[0] = tmp;
                end
            end
            default: ;
        endcase
    endtask

    // Full-width reference for the comparison and the output blocks
    task automatic compute_expected();
        int             i;
        logic [N*W-1:0] full_a;
        logic [N*W-1:0] full_b;
        logic [N*W-1:0] full_out;
        for (i = 0; i < N; i++) begin
            full_a[i*W +: W] = op_a[i];
            full_b[i*W +: W] = op_b[i];
        end
        if (full_a > full_b)
            exp_cmp = CMP_GREATER;
        else if (full_a < full_b)
            exp_cmp = CMP_LESS;
        else
            exp_cmp = CMP_EQUAL;
        full_out = (exp_cmp == CMP_LESS) ? full_a : full_a - full_b;
        for (i = 0; i < N; i++)
            exp_out[i] = full_out[i*W +: W];
    endtask

    task automatic run_operation();
        int i;
        for (i = 0; i < N; i++) begin
            @(posedge clk_in);
            load_valid <= 1'b1;
            load_a     <= op_a[i];
            load_b     <= op_b[i];
        end
        @(posedge clk_in);
        load_valid <= 1'b0;
        // Output window starts the cycle after the last load
        for (i = 0; i < N; i++) begin
            @(negedge clk_in);
            check_flag("out_valid", 1'b1, out_valid);
            check_flag("busy", 1'b1, busy);
            check_flag("out_last", i == N - 1, out_last);
            check_result("cmp_result", exp_cmp, cmp_result);
            check_block($sformatf("out_block[%0d]", i), exp_out[i], out_block);
        end
        @(negedge clk_in);
        check_flag("busy", 1'b0, busy);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("out_last", 1'b0, out_last);
        check_result("cmp_result", exp_cmp, cmp_result);
    endtask

    initial begin
        int op;
        lcg_state  = 32'hd4a7_f8b4;
        rst_n      = 1'b0;
        load_valid = 1'b0;
        load_a     = '0;
        load_b     = '0;
        repeat (10) @(posedge clk_in);
        rst_n <= 1'b1;
        @(negedge clk_in);
        check_flag("busy", 1'b0, busy);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("out_last", 1'b0, out_last);
        check_result("cmp_result", CMP_NONE, cmp_result);
        for (op = 0; op < NUM_OPS; op++) begin
            make_operands(op % 4);
            compute_expected();
            run_operation();
        end
        @(negedge clk_in);
        if (valid_count != NUM_OPS * N || last_count != NUM_OPS) begin
            fail_run($sformatf("Wrong framing: %0d valid cycles and %0d last pulses",
                               valid_count, last_count));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+hw
hw/bignum_pkg.sv
hw/running_comparator.sv
hw/block_subtractor.sv
hw/reduce_sequencer.sv
hw/cond_reduce_top.sv
tb/cond_reduce_checker.sv
tb/cond_reduce_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module cond_reduce_tb \
    -f vlog.f -Mdir obj_dir || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vcond_reduce_tb > sim.log 2>&1
cat sim.log

grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || { echo "No pass message in log"; exit 1; }
exit 0
